/* src/radar_pkg.sv */
//////////////////////////////////////////////////////////////////////
// radar_pkg
// shared widths, register map, state/mode enums and bus structs for
// the marine radar pulse digitizer
//////////////////////////////////////////////////////////////////////

package radar_pkg;

   localparam int sample_w = 12;  // adc sample width
   localparam int out_w    = 16;  // output stream sample width
   localparam int cnt_w    = 32;  // counters, intervals, apb data
   localparam int addr_w   = 8;   // apb byte address
   localparam int half_w   = cnt_w / 2;  // decim rate, threshold fields

   // full-scale value used to negate video
   localparam logic [sample_w-1:0] vid_full_scale = '1;

   // register map, byte addresses
   localparam logic [addr_w-1:0] reg_ctrl          = 8'h00;  // [0] enable [3:1] mode [4] negate
   localparam logic [addr_w-1:0] reg_decim         = 8'h04;
   localparam logic [addr_w-1:0] reg_trig_thr      = 8'h08;  // excite low half, relax high half
   localparam logic [addr_w-1:0] reg_arp_thr       = 8'h0c;
   localparam logic [addr_w-1:0] reg_acp_thr       = 8'h10;
   localparam logic [addr_w-1:0] reg_n_samples     = 8'h14;
   localparam logic [addr_w-1:0] reg_status        = 8'h18;  // [0] overrun, write 1 to clear
   localparam logic [addr_w-1:0] reg_n_trigs       = 8'h1c;
   localparam logic [addr_w-1:0] reg_n_arps        = 8'h20;
   localparam logic [addr_w-1:0] reg_n_acps        = 8'h24;
   localparam logic [addr_w-1:0] reg_trig_interval = 8'h28;
   localparam logic [addr_w-1:0] reg_acp_per_rev   = 8'h2c;

   typedef enum logic [2:0] {
      mode_pulsed     = 3'd0,  // trigger-synced video capture
      mode_raw_video  = 3'd1,
      mode_raw_trig   = 3'd2,
      mode_raw_arp    = 3'd3,
      mode_raw_acp    = 3'd4,
      mode_interleave = 3'd5   // all four channels in turn
   } radar_mode_e;

   typedef enum logic {det_relaxed, det_excited} det_state_e;
   typedef enum logic {cap_idle, cap_capturing} cap_state_e;

   typedef struct packed {
      logic [sample_w-1:0] excite;
      logic [sample_w-1:0] relax;
   } thresh_t;

   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [addr_w-1:0] paddr;
      logic [cnt_w-1:0]  pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [cnt_w-1:0] prdata;
      logic             pready;
      logic             pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic              enable;
      radar_mode_e       mode;
      logic              vid_negate;
      logic [half_w-1:0] decim_rate;
      logic [cnt_w-1:0]  n_samples;
      thresh_t           trig_thr;
      thresh_t           arp_thr;
      thresh_t           acp_thr;
   } radar_cfg_t;

   typedef struct packed {
      logic [sample_w-1:0] video;
      logic [sample_w-1:0] trig;
      logic [sample_w-1:0] arp;
      logic [sample_w-1:0] acp;
   } channels_t;

   typedef struct packed {
      logic [cnt_w-1:0] count;
      logic [cnt_w-1:0] interval;
   } pulse_stats_t;

   typedef struct packed {
      logic [out_w-1:0] data;
      logic             first;  // first sample of a pulse capture
   } sample_t;

endpackage

/* src/radar_regs.sv */
//////////////////////////////////////////////////////////////////////
// radar_regs
// apb slave holding the digitizer configuration, reading back the
// pulse counters and keeping the sticky overrun flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module radar_regs import radar_pkg::*;
(
   input  logic             clk64,
   input  logic             rx_dsp_reset,
   input  apb_req_t         apb_req,
   output apb_rsp_t         apb_rsp,
   output radar_cfg_t       cfg,
   input  pulse_stats_t     trig_stats,
   input  pulse_stats_t     arp_stats,
   input  pulse_stats_t     acp_stats,
   input  logic [cnt_w-1:0] acp_per_rev,
   input  logic             overrun
);

   logic             access;       // apb access phase
   logic             wr;
   logic             mapped;       // address hits a register
   logic [cnt_w-1:0] rdata;
   logic             overrun_flag; // sticky

   // threshold word: excite in low half, relax in high half
   function automatic thresh_t to_thr(input logic [cnt_w-1:0] w);
      thresh_t t;
      t.excite = w[sample_w-1:0];
      t.relax  = w[half_w +: sample_w];
      return t;
   endfunction

   function automatic logic [cnt_w-1:0] thr_word(input thresh_t t);
      return {half_w'(t.relax), half_w'(t.excite)};
   endfunction

   assign access = apb_req.psel & apb_req.penable;
   assign wr     = access & apb_req.pwrite;

   // readback mux and address decode
   always_comb
   begin
      mapped = 1'b1;
      rdata  = '0;
      case (apb_req.paddr)
         reg_ctrl:          rdata = cnt_w'({cfg.vid_negate, cfg.mode, cfg.enable});
         reg_decim:         rdata = cnt_w'(cfg.decim_rate);
         reg_trig_thr:      rdata = thr_word(cfg.trig_thr);
         reg_arp_thr:       rdata = thr_word(cfg.arp_thr);
         reg_acp_thr:       rdata = thr_word(cfg.acp_thr);
         reg_n_samples:     rdata = cfg.n_samples;
         reg_status:        rdata = cnt_w'(overrun_flag);
         reg_n_trigs:       rdata = trig_stats.count;
         reg_n_arps:        rdata = arp_stats.count;
         reg_n_acps:        rdata = acp_stats.count;
         reg_trig_interval: rdata = trig_stats.interval;
         reg_acp_per_rev:   rdata = acp_per_rev;
         default:           mapped = 1'b0;  // unmapped, flagged below
      endcase
   end

   assign apb_rsp.prdata  = rdata;
   assign apb_rsp.pready  = 1'b1;  // zero wait states
   assign apb_rsp.pslverr = access & ~mapped;

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         cfg          <= '0;
         overrun_flag <= 1'b0;
      end
      else
      begin
         if (wr)
         begin
            case (apb_req.paddr)
               reg_ctrl:
               begin
                  cfg.enable     <= apb_req.pwdata[0];
                  cfg.mode       <= radar_mode_e'(apb_req.pwdata[3:1]);
                  cfg.vid_negate <= apb_req.pwdata[4];
               end
               reg_decim:     cfg.decim_rate <= apb_req.pwdata[half_w-1:0];
               reg_trig_thr:  cfg.trig_thr   <= to_thr(apb_req.pwdata);
               reg_arp_thr:   cfg.arp_thr    <= to_thr(apb_req.pwdata);
               reg_acp_thr:   cfg.acp_thr    <= to_thr(apb_req.pwdata);
               reg_n_samples: cfg.n_samples  <= apb_req.pwdata;
               default:       ;  // counters are read only
            endcase
         end
         // a new overrun wins over a clear in the same cycle
         if (overrun)
            overrun_flag <= 1'b1;
         else if (wr && apb_req.paddr == reg_status && apb_req.pwdata[0])
            overrun_flag <= 1'b0;
      end
   end

endmodule

/* src/pulse_detector.sv */
//////////////////////////////////////////////////////////////////////
// pulse_detector
// hysteresis threshold detector: one-cycle strobe on each pulse,
// pulse count and the interval between the last two pulses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pulse_detector import radar_pkg::*;
(
   input  logic                clk64,
   input  logic                rx_dsp_reset,
   input  logic                enable,
   input  logic [sample_w-1:0] level,
   input  thresh_t             thr,
   output logic                strobe,
   output pulse_stats_t        stats
);

   det_state_e       state;
   logic [cnt_w-1:0] age;  // cycles since the last strobe

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         state  <= det_relaxed;
         strobe <= 1'b0;
         stats  <= '0;
         age    <= '0;
      end
      else
      begin
         strobe <= 1'b0;      // single cycle
         age    <= age + 1'b1;
         case (state)
            det_relaxed:
            begin
               if (enable && level >= thr.excite)
               begin
                  state          <= det_excited;
                  strobe         <= 1'b1;
                  stats.count    <= stats.count + 1'b1;
                  stats.interval <= age + 1'b1;  // age is 0 in the strobe cycle
                  age            <= '0;
               end
            end
            det_excited:
            begin
               if (level < thr.relax)  // drop below relax rearms
                  state <= det_relaxed;
            end
            default: state <= det_relaxed;
         endcase
      end
   end

endmodule

/* src/heading_tracker.sv */
//////////////////////////////////////////////////////////////////////
// heading_tracker
// counts ACP strobes between ARP strobes, latching ACPs per antenna
// revolution on every heading pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module heading_tracker import radar_pkg::*;
(
   input  logic             clk64,
   input  logic             rx_dsp_reset,
   input  logic             arp_strobe,
   input  logic             acp_strobe,
   output logic [cnt_w-1:0] acp_per_rev
);

   logic [cnt_w-1:0] acp_run;  // ACPs in the current revolution

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         acp_run     <= '0;
         acp_per_rev <= '0;
      end
      else if (arp_strobe)
      begin
         acp_per_rev <= acp_run;
         // coincident ACP belongs to the new revolution
         acp_run     <= cnt_w'(acp_strobe);
      end
      else if (acp_strobe)
      begin
         acp_run <= acp_run + 1'b1;
      end
   end

endmodule

/* src/sample_pipeline.sv */
//////////////////////////////////////////////////////////////////////
// sample_pipeline
// decimates the channels, runs the pulsed/raw capture controller,
// selects the sample by mode and holds it on a valid/ready stream
// with overrun detection
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sample_pipeline import radar_pkg::*;
(
   input  logic       clk64,
   input  logic       rx_dsp_reset,
   input  radar_cfg_t cfg,
   input  channels_t  chan,
   input  logic       trigger,
   output sample_t    sample,
   output logic       sample_valid,
   input  logic       sample_ready,
   output logic       overrun
);

   logic [half_w-1:0]   dcnt;        // decimation counter
   logic [half_w-1:0]   rate_m1;
   logic                tick;
   logic                pulsed;
   logic                streaming;   // any raw or interleave mode
   cap_state_e          cap_state;
   logic [cnt_w-1:0]    remaining;   // samples left in this capture
   logic                first_pend;  // next take is the first of a pulse
   logic [1:0]          ilv_idx;     // interleave channel
   logic                take;
   logic [sample_w-1:0] sel;

   assign rate_m1   = (cfg.decim_rate == '0) ? '0 : cfg.decim_rate - 1'b1;  // rate 0 acts as 1
   assign tick      = (dcnt >= rate_m1);  // >= so a lowered rate wraps at once
   assign pulsed    = (cfg.mode == mode_pulsed);
   assign streaming = cfg.mode inside {mode_raw_video, mode_raw_trig, mode_raw_arp,
                                       mode_raw_acp, mode_interleave};
   assign take      = tick & (streaming ? cfg.enable : (cap_state == cap_capturing));

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || tick)
         dcnt <= '0;
      else
         dcnt <= dcnt + 1'b1;
   end

   // pulsed capture controller
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         cap_state  <= cap_idle;
         remaining  <= '0;
         first_pend <= 1'b0;
      end
      else if (!pulsed || !cfg.enable)
      begin
         cap_state <= cap_idle;  // abandon any capture
      end
      else
      begin
         case (cap_state)
            cap_idle:
            begin
               if (trigger && cfg.n_samples != '0)
               begin
                  cap_state  <= cap_capturing;
                  remaining  <= cfg.n_samples;
                  first_pend <= 1'b1;
               end
            end
            cap_capturing:  // triggers ignored here
            begin
               if (tick)
               begin
                  first_pend <= 1'b0;
                  remaining  <= remaining - 1'b1;
                  if (remaining == cnt_w'(1))
                     cap_state <= cap_idle;
               end
            end
            default: cap_state <= cap_idle;
         endcase
      end
   end

   // interleave index restarts at video whenever the mode leaves interleave or enable drops
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || cfg.mode != mode_interleave || !cfg.enable)
         ilv_idx <= 2'd0;
      else if (take)
         ilv_idx <= ilv_idx + 1'b1;
   end

   // channel select
   always_comb
   begin
      case (cfg.mode)
         mode_pulsed:    sel = cfg.vid_negate ? vid_full_scale - chan.video : chan.video;
         mode_raw_video: sel = chan.video;
         mode_raw_trig:  sel = chan.trig;
         mode_raw_arp:   sel = chan.arp;
         mode_raw_acp:   sel = chan.acp;
         mode_interleave:
         begin
            case (ilv_idx)
               2'd0:    sel = chan.video;
               2'd1:    sel = chan.trig;
               2'd2:    sel = chan.arp;
               default: sel = chan.acp;
            endcase
         end
         default:        sel = '0;  // reserved mode, never taken
      endcase
   end

   // one-entry output register
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         sample_valid <= 1'b0;
         overrun      <= 1'b0;
      end
      else
      begin
         overrun <= 1'b0;
         if (take && sample_valid && !sample_ready)
            overrun <= 1'b1;      // slot still full, sample dropped
         else if (take)
            sample_valid <= 1'b1;
         else if (sample_ready)
            sample_valid <= 1'b0;  // accepted, nothing new
      end
   end

   always_ff @(posedge clk64)
   begin
      if (take && !(sample_valid && !sample_ready))
      begin
         sample.data  <= out_w'(sel);  // zero extend
         sample.first <= pulsed & first_pend;
      end
   end

endmodule

/* src/radar_digitizer.sv */
//////////////////////////////////////////////////////////////////////
// radar_digitizer
// marine radar pulse digitizer top: apb register bank, trigger/ARP/
// ACP detectors, heading tracker and the sample stream pipeline
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module radar_digitizer import radar_pkg::*;
(
   input  logic      clk64,
   input  logic      rx_dsp_reset,
   input  apb_req_t  apb_req,
   output apb_rsp_t  apb_rsp,
   input  channels_t chan,
   output sample_t   sample,
   output logic      sample_valid,
   input  logic      sample_ready
);

   radar_cfg_t       cfg;
   pulse_stats_t     trig_stats;
   pulse_stats_t     arp_stats;
   pulse_stats_t     acp_stats;
   logic             trig_strobe;
   logic             arp_strobe;
   logic             acp_strobe;
   logic [cnt_w-1:0] acp_per_rev;
   logic             overrun;  // one-cycle drop pulse

   radar_regs regs0 (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .apb_req      (apb_req),
      .apb_rsp      (apb_rsp),
      .cfg          (cfg),
      .trig_stats   (trig_stats),
      .arp_stats    (arp_stats),
      .acp_stats    (acp_stats),
      .acp_per_rev  (acp_per_rev),
      .overrun      (overrun)
   );

   // each detector watches its own fixed channel
   pulse_detector trig_det (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .enable       (cfg.enable),
      .level        (chan.trig),
      .thr          (cfg.trig_thr),
      .strobe       (trig_strobe),
      .stats        (trig_stats)
   );

   pulse_detector arp_det (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .enable       (cfg.enable),
      .level        (chan.arp),
      .thr          (cfg.arp_thr),
      .strobe       (arp_strobe),
      .stats        (arp_stats)
   );

   pulse_detector acp_det (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .enable       (cfg.enable),
      .level        (chan.acp),
      .thr          (cfg.acp_thr),
      .strobe       (acp_strobe),
      .stats        (acp_stats)
   );

   heading_tracker hdg0 (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .arp_strobe   (arp_strobe),
      .acp_strobe   (acp_strobe),
      .acp_per_rev  (acp_per_rev)
   );

   sample_pipeline pipe0 (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .cfg          (cfg),
      .chan         (chan),
      .trigger      (trig_strobe),
      .sample       (sample),
      .sample_valid (sample_valid),
      .sample_ready (sample_ready),
      .overrun      (overrun)
   );

endmodule

/* verification/radar_digitizer_assert.sv */
//////////////////////////////////////////////////////////////////////
// radar_digitizer_assert
// protocol checks on the apb slave, the sample stream and the
// detector strobes, bound into the digitizer top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module radar_digitizer_assert import radar_pkg::*;
(
   input logic     clk64,
   input logic     rx_dsp_reset,
   input apb_req_t apb_req,
   input apb_rsp_t apb_rsp,
   input sample_t  sample,
   input logic     sample_valid,
   input logic     sample_ready,
   input logic     trig_strobe,
   input logic     arp_strobe,
   input logic     acp_strobe
);

   // zero wait state slave
   a_pready: assert property (@(posedge clk64) disable iff (rx_dsp_reset) apb_rsp.pready)
      else $error("pready went low");

   a_slverr: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
      else $error("pslverr outside the access phase");

   // stalled sample must hold
   a_hold: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      (sample_valid && !sample_ready) |=> (sample_valid && $stable(sample)))
      else $error("stream sample changed while stalled");

   a_strobes: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      (trig_strobe |=> !trig_strobe) and (arp_strobe |=> !arp_strobe)
      and (acp_strobe |=> !acp_strobe))
      else $error("detector strobe lasted two cycles");

endmodule

bind radar_digitizer radar_digitizer_assert assert0 (
   .clk64        (clk64),
   .rx_dsp_reset (rx_dsp_reset),
   .apb_req      (apb_req),
   .apb_rsp      (apb_rsp),
   .sample       (sample),
   .sample_valid (sample_valid),
   .sample_ready (sample_ready),
   .trig_strobe  (trig_strobe),
   .arp_strobe   (arp_strobe),
   .acp_strobe   (acp_strobe)
);

/* verification/radar_digitizer_tb.sv */
//////////////////////////////////////////////////////////////////////
// radar_digitizer_tb
// random stimulus for the radar digitizer with a reference model for
// pulse counts, heading and the sample stream
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module radar_digitizer_tb import radar_pkg::*;
();

   // cycle budget per test, in order, plus a margin
   localparam int planned_cycles = 150 + 700 + 250 + 400 + 150 + 100;
   localparam int cycle_limit    = planned_cycles + 500;

   logic      clk64 = 1'b0;
   logic      rx_dsp_reset;
   apb_req_t  apb_req;
   apb_rsp_t  apb_rsp;
   channels_t chan;
   sample_t   sample;
   logic      sample_valid;
   logic      sample_ready;

   channels_t cur;            // channel values driven next
   sample_t   got_q[$];       // accepted stream samples
   int        cycles = 0;
   int        test_errs = 0;
   int        passed = 0;
   int        failed = 0;

   // model state, index 0 trig, 1 arp, 2 acp
   logic [sample_w-1:0] m_exc_thr[3];
   logic [sample_w-1:0] m_rel_thr[3];
   logic                m_excited[3];
   int                  m_cnt[3];
   int                  m_cyc;
   int                  last_cross;
   int                  prev_cross;
   int                  n_cross;

   radar_digitizer dut0 (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .apb_req      (apb_req),
      .apb_rsp      (apb_rsp),
      .chan         (chan),
      .sample       (sample),
      .sample_valid (sample_valid),
      .sample_ready (sample_ready)
   );

   always #2 clk64 = ~clk64;  // 4 ns period

   // collect every transfer
   always @(posedge clk64)
   begin
      if (!rx_dsp_reset && sample_valid && sample_ready)
         got_q.push_back(sample);
   end

   // run limit
   always @(posedge clk64)
   begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit)
      begin
         $display("timeout: run exceeded %0d cycles", cycle_limit);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("MISMATCH at %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
         test_errs++;
      end
   endtask

   task automatic finish_test(input string name);
      if (test_errs == 0)
         passed++;
      else
         failed++;
      $display("test %-12s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "FAILED", test_errs);
      test_errs = 0;
   endtask

   task automatic apb_write(input logic [addr_w-1:0] addr, input logic [cnt_w-1:0] data);
      @(posedge clk64);
      apb_req.psel    <= 1'b1;  // setup phase
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= 1'b1;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= data;
      @(posedge clk64);
      apb_req.penable <= 1'b1;
      @(posedge clk64);         // write lands on this edge
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [addr_w-1:0] addr, output logic [cnt_w-1:0] data,
                           output logic err);
      @(posedge clk64);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= 1'b0;
      apb_req.paddr   <= addr;
      @(posedge clk64);
      apb_req.penable <= 1'b1;
      @(posedge clk64);
      data = apb_rsp.prdata;    // access phase values
      err  = apb_rsp.pslverr;
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic read_check(input logic [addr_w-1:0] addr, input logic [31:0] exp,
                             input string what);
      logic [cnt_w-1:0] d;
      logic             e;
      apb_read(addr, d, e);
      assert (!e)
      else
      begin
         $display("read of mapped address 0x%0h raised pslverr", addr);
         test_errs++;
      end
      check_eq(what, d, exp);
   endtask

   task automatic set_model_thr(input int i, input logic [cnt_w-1:0] word);
      m_exc_thr[i] = word[sample_w-1:0];
      m_rel_thr[i] = word[half_w +: sample_w];
   endtask

   // one cycle of channel drive, the model sees the same level as the DUT
   task automatic step(input channels_t c);
      logic [sample_w-1:0] lv[3];
      @(posedge clk64);
      chan <= c;
      lv[0] = c.trig;
      lv[1] = c.arp;
      lv[2] = c.acp;
      for (int i = 0; i < 3; i++)
      begin
         if (!m_excited[i] && lv[i] >= m_exc_thr[i])
         begin
            m_excited[i] = 1'b1;
            m_cnt[i]++;
            if (i == 0)
            begin
               prev_cross = last_cross;
               last_cross = m_cyc;
               n_cross++;
            end
         end
         else if (m_excited[i] && lv[i] < m_rel_thr[i])
            m_excited[i] = 1'b0;  // hysteresis rearm
      end
      m_cyc++;
   endtask

   // two cycles high then two low on one channel
   task automatic pulse(input int ch);
      for (int k = 0; k < 4; k++)
      begin
         if (ch == 0)
            cur.trig = (k < 2) ? 12'd3000 : 12'd0;
         else if (ch == 1)
            cur.arp = (k < 2) ? 12'd3000 : 12'd0;
         else
            cur.acp = (k < 2) ? 12'd3000 : 12'd0;
         step(cur);
      end
   endtask

   task automatic wait_samples(input int n);
      while (got_q.size() < n)
         @(posedge clk64);
   endtask

   initial
   begin
      logic [addr_w-1:0] addrs[6];
      logic [31:0]       masks[6];
      logic [31:0]       vals[6];
      logic [cnt_w-1:0]  rd;
      logic              err;
      logic [cnt_w-1:0]  w;
      int                hold[3];
      int                n;
      int                n_last;
      int                decim;
      logic              neg;
      logic [sample_w-1:0] exp_s;
      sample_t           held;

      void'($urandom(60));
      rx_dsp_reset = 1'b1;
      apb_req      = '0;
      chan         = '0;
      cur          = '0;
      sample_ready = 1'b1;
      for (int i = 0; i < 3; i++)
      begin
         m_exc_thr[i] = '1;
         m_rel_thr[i] = '0;
         m_excited[i] = 1'b0;
         m_cnt[i]     = 0;
      end
      m_cyc      = 0;
      last_cross = 0;
      prev_cross = 0;
      n_cross    = 0;
      repeat (4) @(posedge clk64);
      rx_dsp_reset <= 1'b0;

      // 1: register readback, enable kept low
      addrs = '{reg_ctrl, reg_decim, reg_trig_thr, reg_arp_thr, reg_acp_thr, reg_n_samples};
      masks = '{32'h1e, 32'hffff, 32'h0fff0fff, 32'h0fff0fff, 32'h0fff0fff, 32'hffffffff};
      for (int i = 0; i < 6; i++)
      begin
         vals[i] = $urandom() & masks[i];
         apb_write(addrs[i], vals[i]);
      end
      for (int i = 0; i < 6; i++)
         read_check(addrs[i], vals[i], "register readback");
      apb_read(8'h40, rd, err);
      assert (err)
      else
      begin
         $display("read of unmapped address 0x40 did not raise pslverr");
         test_errs++;
      end
      apb_write(8'h40, $urandom());
      for (int i = 0; i < 6; i++)
         read_check(addrs[i], vals[i], "register after unmapped write");
      finish_test("registers");

      // 2: random hysteresis waveforms on all three detectors
      for (int i = 0; i < 3; i++)
      begin
         w = 1000 + $urandom() % 2000;          // excite
         w = w | ((w - 100 - $urandom() % 400) << 16);  // relax below it
         apb_write(addrs[2 + i], w);
         set_model_thr(i, w);
         hold[i] = 0;
      end
      apb_write(reg_ctrl, 32'h3);  // enable, raw video
      for (int c = 0; c < 600; c++)
      begin
         for (int i = 0; i < 3; i++)
         begin
            if (hold[i] == 0)
            begin
               hold[i] = 2 + $urandom() % 5;
               w = $urandom() % 4096;
               if (i == 0) cur.trig = w[11:0];
               else if (i == 1) cur.arp = w[11:0];
               else cur.acp = w[11:0];
            end
            hold[i]--;
         end
         step(cur);
      end
      cur = '0;
      repeat (4) step(cur);
      read_check(reg_n_trigs, m_cnt[0], "trigger count");
      read_check(reg_n_arps, m_cnt[1], "arp count");
      read_check(reg_n_acps, m_cnt[2], "acp count");
      if (n_cross >= 2)
         read_check(reg_trig_interval, last_cross - prev_cross, "trigger interval");
      finish_test("pulse count");

      // 3: heading, acps between arps
      w = (32'd1000 << 16) | 32'd2000;
      apb_write(reg_arp_thr, w);
      apb_write(reg_acp_thr, w);
      set_model_thr(1, w);
      set_model_thr(2, w);
      n_last = 0;
      for (int r = 0; r < 5; r++)
      begin
         pulse(1);
         n = 1 + $urandom() % 8;
         repeat (n) pulse(2);
         n_last = n;
      end
      pulse(1);  // closes the last revolution
      repeat (2) step(cur);
      read_check(reg_acp_per_rev, n_last, "acps per revolution");
      finish_test("heading");

      // 4: raw and interleave streaming
      decim = 1 + $urandom() % 4;
      apb_write(reg_decim, decim);
      for (int m = 1; m <= 5; m++)
      begin
         apb_write(reg_ctrl, 32'h0);
         cur = channels_t'({$urandom(), $urandom()});
         step(cur);
         repeat (4) @(posedge clk64);
         got_q.delete();
         apb_write(reg_ctrl, (m << 1) | 1);
         wait_samples(8);
         for (int k = 0; k < 8; k++)
         begin
            case ((m == 5) ? k % 4 + 1 : m)
               1:       exp_s = cur.video;
               2:       exp_s = cur.trig;
               3:       exp_s = cur.arp;
               default: exp_s = cur.acp;
            endcase
            check_eq($sformatf("mode %0d sample %0d", m, k), got_q[k].data, exp_s);
         end
      end
      finish_test("raw modes");

      // 5: pulsed capture with a retrigger inside the window
      apb_write(reg_ctrl, 32'h0);
      w = (32'd1000 << 16) | 32'd2000;
      apb_write(reg_trig_thr, w);
      set_model_thr(0, w);
      n     = 6 + $urandom() % 5;
      decim = 1 + $urandom() % 3;
      neg   = $urandom() % 2;
      apb_write(reg_n_samples, n);
      apb_write(reg_decim, decim);
      cur.video = $urandom() % 4096;
      cur.trig  = '0;
      step(cur);
      repeat (4) @(posedge clk64);
      got_q.delete();
      apb_write(reg_ctrl, (neg << 4) | 32'h1);
      pulse(0);
      pulse(0);  // lands while capturing
      wait_samples(n);
      repeat (n * decim + 20) @(posedge clk64);
      check_eq("capture length", got_q.size(), n);
      exp_s = neg ? 12'hfff - cur.video : cur.video;
      for (int k = 0; k < got_q.size(); k++)
      begin
         check_eq($sformatf("pulsed sample %0d", k), got_q[k].data, exp_s);
         check_eq($sformatf("first flag %0d", k), got_q[k].first, k == 0);
      end
      finish_test("pulsed");

      // 6: stall the stream, overrun sticks until cleared
      apb_write(reg_ctrl, 32'h0);
      apb_write(reg_decim, 2);
      @(posedge clk64);
      sample_ready <= 1'b0;
      cur.video = $urandom() % 4096;
      step(cur);
      apb_write(reg_ctrl, 32'h3);
      while (!sample_valid)
         @(posedge clk64);
      held  = sample;
      exp_s = cur.video;
      cur.video = ~cur.video;  // later ticks see a different value
      step(cur);
      repeat (10) @(posedge clk64);
      check_eq("held sample", sample, held);
      check_eq("held data", sample.data, exp_s);
      check_eq("held valid", sample_valid, 1'b1);
      apb_write(reg_ctrl, 32'h0);  // stop new ticks before the clear
      read_check(reg_status, 1, "overrun set");
      apb_write(reg_status, 1);
      read_check(reg_status, 0, "overrun cleared");
      @(posedge clk64);
      sample_ready <= 1'b1;
      repeat (4) @(posedge clk64);
      finish_test("backpressure");

      $display("tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
      if (failed == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

/* radar_digitizer.f */
src/radar_pkg.sv
src/radar_regs.sv
src/pulse_detector.sv
src/heading_tracker.sv
src/sample_pipeline.sv
src/radar_digitizer.sv
verification/radar_digitizer_assert.sv
verification/radar_digitizer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the radar digitizer testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module radar_digitizer_tb \
   -f radar_digitizer.f -o radar_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/radar_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Some tests failed" sim.log; then
   exit 1
fi
exit 0
